// File: rv32_exec_unit.f
+incdir+tb
rtl/exu_pkg.sv
rtl/exu_operand_regs.sv
rtl/exu_alu.sv
rtl/exu_branch_unit.sv
rtl/exu_result_select.sv
rtl/exu_top.sv
tb/exu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the execute unit testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -f rv32_exec_unit.f -o exu_sim \
        > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/exu_sim > sim.log 2>&1
cat sim.log

grep -qx ">>> PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/exu_ref_model.svh
`ifndef EXU_REF_MODEL_SVH
`define EXU_REF_MODEL_SVH

// expected state of the outputs for one strobed instruction
typedef struct packed {
        logic        valid;
        logic        rd_write;
        logic [4:0]  rd_addr;
        logic [31:0] result;
        logic        taken;
        logic [31:0] branch_addr;
        logic        jal;
        logic [31:0] jal_addr;
        logic        jalr;
        logic [31:0] jalr_addr;
} exp_t;

// RV32I rules applied to the raw instruction word
function automatic exp_t exu_ref(input logic [31:0] instr, input logic [31:0] pc,
                                 input logic [31:0] x, input logic [31:0] rs2,
                                 input logic lui, input logic auipc, input logic jal,
                                 input logic jalr, input logic branch, input logic use_imm,
                                 input logic rd_write);
        exp_t        e;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] y;
        logic [31:0] alu;
        logic [4:0]  sh;
        logic        cond;

        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        imm_u = {instr[31:12], 12'd0};
        y     = use_imm ? imm_i : rs2;
        sh    = y[4:0];

        // funct3 000 subtracts only for register-register
        case (instr[14:12])
                3'd0: alu = (instr[6:0] == exu_pkg::OPC_OP && instr[30]) ? x - y : x + y;
                3'd1: alu = x << sh;
                3'd2: alu = {31'd0, $signed(x) < $signed(y)};
                3'd3: alu = {31'd0, x < y};
                3'd4: alu = x ^ y;
                3'd5: begin
                        if (instr[30])
                                alu = $signed(x) >>> sh;
                        else
                                alu = x >> sh;
                end
                3'd6: alu = x | y;
                default: alu = x & y;
        endcase

        case (instr[14:12])
                3'd0: cond = (x == rs2);
                3'd1: cond = (x != rs2);
                3'd4: cond = ($signed(x) < $signed(rs2));
                3'd5: cond = ($signed(x) >= $signed(rs2));
                3'd6: cond = (x < rs2);
                3'd7: cond = (x >= rs2);
                default: cond = 1'b0;
        endcase

        e.valid       = 1'b1;
        e.rd_write    = rd_write;
        e.rd_addr     = instr[11:7];
        e.result      = lui ? imm_u : auipc ? imm_u + pc : (jal | jalr) ? pc + 32'd4 : alu;
        e.taken       = branch & cond;
        e.branch_addr = pc + imm_b;
        e.jal         = jal;
        e.jal_addr    = pc + imm_j;
        e.jalr        = jalr;
        e.jalr_addr   = (x + imm_i) & ~32'd1;
        return e;
endfunction

`endif

// File: tb/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;

        localparam int PC_W    = 32;
        localparam int STROBES = 200;
        localparam int TESTS   = 6;
        // all strobes plus half again for idle gaps, with reset margin on top
        localparam int TIMEOUT_CYCLES = TESTS * STROBES * 3 / 2 + 200;

        `include "exu_ref_model.svh"

        logic        clk;
        logic        reset_n;
        logic        enable;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        ctl_lui, ctl_auipc, ctl_jal, ctl_jalr;
        logic        ctl_branch, ctl_imm, ctl_rd_write;
        logic        valid, rd_write, branch_taken, jal, jalr;
        logic [4:0]  rd_addr;
        logic [31:0] result, branch_addr, jal_addr, jalr_addr;

        integer seed;
        int     err_count;
        int     check_count;
        int     pushed;
        int     checked;
        int     cycles;
        exp_t   exp_q[$];

        exu_top #(.PC_WIDTH(PC_W)) dut0 (
                .clk(clk), .reset_n(reset_n), .enable_i(enable), .instr_i(instr),
                .pc_i(pc), .rs1_i(rs1), .rs2_i(rs2),
                .ctl_lui_i(ctl_lui), .ctl_auipc_i(ctl_auipc), .ctl_jal_i(ctl_jal),
                .ctl_jalr_i(ctl_jalr), .ctl_branch_i(ctl_branch), .ctl_imm_i(ctl_imm),
                .ctl_rd_write_i(ctl_rd_write),
                .valid_o(valid), .rd_write_o(rd_write), .rd_addr_o(rd_addr),
                .result_o(result), .branch_taken_o(branch_taken),
                .branch_addr_o(branch_addr), .jal_o(jal), .jal_addr_o(jal_addr),
                .jalr_o(jalr), .jalr_addr_o(jalr_addr)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // --------------------------------------------------
        // checking
        // --------------------------------------------------
        task automatic check_field(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
                check_count++;
                assert (act_v === exp_v) else begin
                        $display("Mismatch at %0t: %s expected %h, got %h",
                                 $time, name, exp_v, act_v);
                        err_count++;
                end
        endtask

        task automatic compare_outputs(input exp_t e);
                check_field("valid_o", 32'(e.valid), 32'(valid));
                check_field("rd_write_o", 32'(e.rd_write), 32'(rd_write));
                check_field("rd_addr_o", 32'(e.rd_addr), 32'(rd_addr));
                check_field("result_o", e.result, result);
                check_field("branch_taken_o", 32'(e.taken), 32'(branch_taken));
                check_field("branch_addr_o", e.branch_addr, branch_addr);
                check_field("jal_o", 32'(e.jal), 32'(jal));
                check_field("jal_addr_o", e.jal_addr, jal_addr);
                check_field("jalr_o", 32'(e.jalr), 32'(jalr));
                check_field("jalr_addr_o", e.jalr_addr, jalr_addr);
        endtask

        // nothing strobed at the last edge
        task automatic check_quiet();
                check_field("valid_o", 32'd0, 32'(valid));
                check_field("rd_write_o", 32'd0, 32'(rd_write));
                check_field("branch_taken_o", 32'd0, 32'(branch_taken));
                check_field("jal_o", 32'd0, 32'(jal));
                check_field("jalr_o", 32'd0, 32'(jalr));
        endtask

        // outputs settle just after the capturing edge
        initial begin
                exp_t cur;
                forever begin
                        @(posedge clk);
                        #1;
                        if (exp_q.size() > 0) begin
                                cur = exp_q.pop_front();
                                compare_outputs(cur);
                                checked++;
                        end else begin
                                check_quiet();
                        end
                end
        end

        initial begin
                cycles = 0;
                forever begin
                        @(posedge clk);
                        cycles++;
                        if (cycles >= TIMEOUT_CYCLES) begin
                                $display("run timed out after %0d cycles", cycles);
                                $display(">>> FAIL");
                                $finish;
                        end
                end
        end

        // --------------------------------------------------
        // stimulus, driven on the falling edge
        // --------------------------------------------------
        // fl is {lui, auipc, jal, jalr, branch, imm, rd_write}
        task automatic strobe_instr(input logic [31:0] ins, input logic [6:0] fl);
                logic [31:0] r;

                @(negedge clk);
                r   = $random(seed);
                pc  = r & 32'hffff_fffc;
                rs1 = $random(seed);
                rs2 = $random(seed);
                // ties now and then for BEQ and BGE
                if (($random(seed) & 7) == 0)
                        rs2 = rs1;
                instr  = ins;
                enable = 1'b1;
                {ctl_lui, ctl_auipc, ctl_jal, ctl_jalr, ctl_branch, ctl_imm, ctl_rd_write} = fl;
                exp_q.push_back(exu_ref(ins, pc, rs1, rs2, fl[6], fl[5], fl[4], fl[3],
                                        fl[2], fl[1], fl[0]));
                pushed++;
        endtask

        // flags toggle without a strobe and must not leak out
        task automatic idle_cycle();
                logic [31:0] r;

                @(negedge clk);
                r      = $random(seed);
                enable = 1'b0;
                {ctl_lui, ctl_auipc, ctl_jal, ctl_jalr, ctl_branch, ctl_imm, ctl_rd_write} = r[6:0];
                instr  = $random(seed);
        endtask

        task automatic send_class(input int kind);
                logic [31:0] r;
                logic [31:0] r2;
                logic [2:0]  f3;
                logic        alt;
                logic [11:0] imm;

                r   = $random(seed);
                r2  = $random(seed);
                f3  = r[14:12];
                alt = r[30];
                case (kind)
                        0: begin
                                if (f3 != 3'd0 && f3 != 3'd5)
                                        alt = 1'b0;
                                strobe_instr({1'b0, alt, 5'd0, r[24:7], exu_pkg::OPC_OP},
                                             {6'd0, r2[0]});
                        end
                        1: begin
                                if (f3 == 3'd1)
                                        imm = {7'd0, r[24:20]};
                                else if (f3 == 3'd5)
                                        imm = {1'b0, alt, 5'd0, r[24:20]};
                                else
                                        imm = r[31:20];
                                strobe_instr({imm, r[19:7], exu_pkg::OPC_OP_IMM},
                                             {5'd0, 1'b1, r2[0]});
                        end
                        2: begin
                                // 010 and 011 are not branches
                                if (f3[2:1] == 2'b01)
                                        f3 = {1'b1, f3[1:0]};
                                strobe_instr({r[31:15], f3, r[11:7], exu_pkg::OPC_BRANCH},
                                             7'b0000100);
                        end
                        3: begin
                                if (r2[1])
                                        strobe_instr({r[31:7], exu_pkg::OPC_JAL}, 7'b0010001);
                                else
                                        strobe_instr({r[31:15], 3'd0, r[11:7], exu_pkg::OPC_JALR},
                                                     7'b0001011);
                        end
                        default: begin
                                if (r2[1])
                                        strobe_instr({r[31:7], exu_pkg::OPC_LUI}, 7'b1000001);
                                else
                                        strobe_instr({r[31:7], exu_pkg::OPC_AUIPC}, 7'b0100001);
                        end
                endcase
        endtask

        task automatic run_test(input string name, input int kind, input logic gaps);
                int errs_before;
                int k;

                errs_before = err_count;
                for (int i = 0; i < STROBES; i++) begin
                        if (gaps && (($random(seed) & 15) == 0))
                                idle_cycle();
                        k = kind;
                        if (kind < 0)
                                k = {$random(seed)} % 5;
                        send_class(k);
                end
                // let the last instruction reach its check
                idle_cycle();
                @(negedge clk);
                $display("test %s: %0d instructions, %0d errors", name, STROBES,
                         err_count - errs_before);
        endtask

        initial begin
                seed         = 32'h4ec2;
                err_count    = 0;
                check_count  = 0;
                pushed       = 0;
                checked      = 0;
                reset_n      = 1'b0;
                enable       = 1'b0;
                instr        = 32'd0;
                pc           = 32'd0;
                rs1          = 32'd0;
                rs2          = 32'd0;
                {ctl_lui, ctl_auipc, ctl_jal, ctl_jalr} = 4'd0;
                {ctl_branch, ctl_imm, ctl_rd_write} = 3'd0;
                repeat (10) @(posedge clk);
                @(negedge clk);
                reset_n = 1'b1;

                run_test("reg-reg alu", 0, 1'b1);
                run_test("reg-imm alu", 1, 1'b1);
                run_test("branch", 2, 1'b1);
                run_test("jal and jalr", 3, 1'b1);
                run_test("lui and auipc", 4, 1'b1);
                run_test("back-to-back mix", -1, 1'b0);

                assert (checked == pushed) else begin
                        $display("only %0d of %0d instructions were checked", checked, pushed);
                        err_count++;
                end
                $display("summary: %0d tests, %0d instructions, %0d checks, %0d errors",
                         TESTS, pushed, check_count, err_count);
                if (err_count == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

// File: rtl/exu_top.sv
`timescale 1ns/1ps

module exu_top #(
        parameter int PC_WIDTH = 32
) (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic                      enable_i,
        input  exu_pkg::instr_u           instr_i,
        input  logic [PC_WIDTH-1:0]       pc_i,
        input  logic [exu_pkg::XLEN-1:0]  rs1_i,
        input  logic [exu_pkg::XLEN-1:0]  rs2_i,
        input  logic                      ctl_lui_i,
        input  logic                      ctl_auipc_i,
        input  logic                      ctl_jal_i,
        input  logic                      ctl_jalr_i,
        input  logic                      ctl_branch_i,
        input  logic                      ctl_imm_i,
        input  logic                      ctl_rd_write_i,
        output logic                      valid_o,
        output logic                      rd_write_o,
        output logic [4:0]                rd_addr_o,
        output logic [exu_pkg::XLEN-1:0]  result_o,
        output logic                      branch_taken_o,
        output logic [PC_WIDTH-1:0]       branch_addr_o,
        output logic                      jal_o,
        output logic [PC_WIDTH-1:0]       jal_addr_o,
        output logic                      jalr_o,
        output logic [PC_WIDTH-1:0]       jalr_addr_o
);

        // --------------------------------------------------
        // registered execute state
        // --------------------------------------------------
        logic [exu_pkg::XLEN-1:0] x_q;
        logic [exu_pkg::XLEN-1:0] y_q;
        exu_pkg::instr_u          ir_q;
        logic [PC_WIDTH-1:0]      pc_q;
        logic                     lui_q;
        logic                     auipc_q;
        logic                     jal_q;
        logic                     jalr_q;
        logic                     branch_q;
        logic [exu_pkg::XLEN-1:0] alu_result;

        exu_operand_regs #(
                .PC_WIDTH (PC_WIDTH)
        ) u_regs (
                .clk            (clk),
                .reset_n        (reset_n),
                .enable_i       (enable_i),
                .instr_i        (instr_i),
                .pc_i           (pc_i),
                .rs1_i          (rs1_i),
                .rs2_i          (rs2_i),
                .ctl_lui_i      (ctl_lui_i),
                .ctl_auipc_i    (ctl_auipc_i),
                .ctl_jal_i      (ctl_jal_i),
                .ctl_jalr_i     (ctl_jalr_i),
                .ctl_branch_i   (ctl_branch_i),
                .ctl_imm_i      (ctl_imm_i),
                .ctl_rd_write_i (ctl_rd_write_i),
                .valid_o        (valid_o),
                .x_o            (x_q),
                .y_o            (y_q),
                .ir_o           (ir_q),
                .pc_o           (pc_q),
                .lui_o          (lui_q),
                .auipc_o        (auipc_q),
                .jal_o          (jal_q),
                .jalr_o         (jalr_q),
                .branch_o       (branch_q),
                .rd_write_o     (rd_write_o)
        );

        assign rd_addr_o = ir_q.i_fmt.rd;

        exu_alu u_alu (
                .x_i      (x_q),
                .y_i      (y_q),
                .ir_i     (ir_q),
                .result_o (alu_result)
        );

        exu_branch_unit #(
                .PC_WIDTH (PC_WIDTH)
        ) u_branch (
                .x_i            (x_q),
                .y_i            (y_q),
                .ir_i           (ir_q),
                .pc_i           (pc_q),
                .branch_i       (branch_q),
                .jal_i          (jal_q),
                .jalr_i         (jalr_q),
                .branch_taken_o (branch_taken_o),
                .branch_addr_o  (branch_addr_o),
                .jal_o          (jal_o),
                .jal_addr_o     (jal_addr_o),
                .jalr_o         (jalr_o),
                .jalr_addr_o    (jalr_addr_o)
        );

        exu_result_select #(
                .PC_WIDTH (PC_WIDTH)
        ) u_result (
                .alu_result_i (alu_result),
                .ir_i         (ir_q),
                .pc_i         (pc_q),
                .lui_i        (lui_q),
                .auipc_i      (auipc_q),
                .jal_i        (jal_q),
                .jalr_i       (jalr_q),
                .result_o     (result_o)
        );

endmodule

// File: rtl/exu_result_select.sv
`timescale 1ns/1ps

module exu_result_select #(
        parameter int PC_WIDTH = 32
) (
        input  logic [exu_pkg::XLEN-1:0]  alu_result_i,
        input  exu_pkg::instr_u           ir_i,
        input  logic [PC_WIDTH-1:0]       pc_i,
        input  logic                      lui_i,
        input  logic                      auipc_i,
        input  logic                      jal_i,
        input  logic                      jalr_i,
        output logic [exu_pkg::XLEN-1:0]  result_o
);

        logic [exu_pkg::XLEN-1:0] pc_ext;
        logic [exu_pkg::XLEN-1:0] lui_val;
        logic [exu_pkg::XLEN-1:0] auipc_val;
        logic [exu_pkg::XLEN-1:0] link_val;

        // pc zero-extended to the data width
        always_comb begin
                pc_ext               = '0;
                pc_ext[PC_WIDTH-1:0] = pc_i;
        end

        assign lui_val   = {ir_i.u_fmt.imm20, 12'd0};
        assign auipc_val = lui_val + pc_ext;
        // link is always pc+4 without compressed instructions
        assign link_val  = pc_ext + exu_pkg::XLEN'(4);

        // --------------------------------------------------
        // write-back pick by class
        // --------------------------------------------------
        always_comb begin
                if (lui_i) begin
                        result_o = lui_val;
                end else if (auipc_i) begin
                        result_o = auipc_val;
                end else if (jal_i | jalr_i) begin
                        result_o = link_val;
                end else begin
                        result_o = alu_result_i;
                end
        end

        always_comb begin
                a_lui_auipc: assert (!(lui_i && auipc_i))
                        else $error("lui and auipc both active");
        end

endmodule

// File: rtl/exu_branch_unit.sv
`timescale 1ns/1ps

module exu_branch_unit #(
        parameter int PC_WIDTH = 32
) (
        input  logic [exu_pkg::XLEN-1:0]  x_i,
        input  logic [exu_pkg::XLEN-1:0]  y_i,
        input  exu_pkg::instr_u           ir_i,
        input  logic [PC_WIDTH-1:0]       pc_i,
        input  logic                      branch_i,
        input  logic                      jal_i,
        input  logic                      jalr_i,
        output logic                      branch_taken_o,
        output logic [PC_WIDTH-1:0]       branch_addr_o,
        output logic                      jal_o,
        output logic [PC_WIDTH-1:0]       jal_addr_o,
        output logic                      jalr_o,
        output logic [PC_WIDTH-1:0]       jalr_addr_o
);

        logic                     cond;
        logic [exu_pkg::XLEN-1:0] b_off;
        logic [exu_pkg::XLEN-1:0] j_off;
        logic [exu_pkg::XLEN-1:0] i_off;
        logic [exu_pkg::XLEN-1:0] jalr_sum;

        // --------------------------------------------------
        // branch condition
        // --------------------------------------------------
        always_comb begin
                case (ir_i.b_fmt.funct3)
                        exu_pkg::F3_BEQ:  cond = (x_i == y_i);
                        exu_pkg::F3_BNE:  cond = (x_i != y_i);
                        exu_pkg::F3_BLT:  cond = ($signed(x_i) < $signed(y_i));
                        exu_pkg::F3_BGE:  cond = ($signed(x_i) >= $signed(y_i));
                        exu_pkg::F3_BLTU: cond = (x_i < y_i);
                        exu_pkg::F3_BGEU: cond = (x_i >= y_i);
                        default:          cond = 1'b0;
                endcase
        end

        assign branch_taken_o = branch_i & cond;

        // --------------------------------------------------
        // offsets and targets
        // --------------------------------------------------
        assign b_off = {{(exu_pkg::XLEN-12){ir_i.b_fmt.imm12}}, ir_i.b_fmt.imm11,
                        ir_i.b_fmt.imm10_5, ir_i.b_fmt.imm4_1, 1'b0};

        assign j_off = {{(exu_pkg::XLEN-20){ir_i.j_fmt.imm20}}, ir_i.j_fmt.imm19_12,
                        ir_i.j_fmt.imm11, ir_i.j_fmt.imm10_1, 1'b0};

        assign i_off = {{(exu_pkg::XLEN-12){ir_i.i_fmt.imm12[11]}}, ir_i.i_fmt.imm12};

        assign branch_addr_o = pc_i + b_off[PC_WIDTH-1:0];
        assign jal_addr_o    = pc_i + j_off[PC_WIDTH-1:0];

        // jalr target from rs1 with the lowest bit forced clear
        assign jalr_sum    = x_i + i_off;
        assign jalr_addr_o = {jalr_sum[PC_WIDTH-1:1], 1'b0};

        assign jal_o  = jal_i;
        assign jalr_o = jalr_i;

endmodule

// File: rtl/exu_alu.sv
`timescale 1ns/1ps

module exu_alu (
        input  logic [exu_pkg::XLEN-1:0]  x_i,
        input  logic [exu_pkg::XLEN-1:0]  y_i,
        input  exu_pkg::instr_u           ir_i,
        output logic [exu_pkg::XLEN-1:0]  result_o
);

        logic [2:0] funct3;
        logic [4:0] shamt;
        logic       sub_sel;
        logic       sra_sel;

        assign funct3 = ir_i.i_fmt.funct3;
        assign shamt  = y_i[4:0];

        // bit 30 is part of the immediate for OP-IMM, so only OP subtracts
        assign sub_sel = (ir_i.i_fmt.opcode == exu_pkg::OPC_OP) & ir_i.i_fmt.imm12[10];
        assign sra_sel = ir_i.i_fmt.imm12[10];

        always_comb begin
                case (funct3)
                        exu_pkg::F3_ADD_SUB: begin
                                result_o = sub_sel ? (x_i - y_i) : (x_i + y_i);
                        end
                        exu_pkg::F3_SLL: begin
                                result_o = x_i << shamt;
                        end
                        exu_pkg::F3_SLT: begin
                                result_o = {{(exu_pkg::XLEN-1){1'b0}},
                                            ($signed(x_i) < $signed(y_i))};
                        end
                        exu_pkg::F3_SLTU: begin
                                result_o = {{(exu_pkg::XLEN-1){1'b0}}, (x_i < y_i)};
                        end
                        exu_pkg::F3_XOR: begin
                                result_o = x_i ^ y_i;
                        end
                        exu_pkg::F3_SRL_SRA: begin
                                // arithmetic shift keeps the sign
                                if (sra_sel) begin
                                        result_o = $signed(x_i) >>> shamt;
                                end else begin
                                        result_o = x_i >> shamt;
                                end
                        end
                        exu_pkg::F3_OR: begin
                                result_o = x_i | y_i;
                        end
                        default: begin
                                result_o = x_i & y_i;
                        end
                endcase
        end

endmodule

// File: rtl/exu_operand_regs.sv
`timescale 1ns/1ps

module exu_operand_regs #(
        parameter int PC_WIDTH = 32
) (
        input  logic                      clk,
        input  logic                      reset_n,
        input  logic                      enable_i,
        input  exu_pkg::instr_u           instr_i,
        input  logic [PC_WIDTH-1:0]       pc_i,
        input  logic [exu_pkg::XLEN-1:0]  rs1_i,
        input  logic [exu_pkg::XLEN-1:0]  rs2_i,
        input  logic                      ctl_lui_i,
        input  logic                      ctl_auipc_i,
        input  logic                      ctl_jal_i,
        input  logic                      ctl_jalr_i,
        input  logic                      ctl_branch_i,
        input  logic                      ctl_imm_i,
        input  logic                      ctl_rd_write_i,
        output logic                      valid_o,
        output logic [exu_pkg::XLEN-1:0]  x_o,
        output logic [exu_pkg::XLEN-1:0]  y_o,
        output exu_pkg::instr_u           ir_o,
        output logic [PC_WIDTH-1:0]       pc_o,
        output logic                      lui_o,
        output logic                      auipc_o,
        output logic                      jal_o,
        output logic                      jalr_o,
        output logic                      branch_o,
        output logic                      rd_write_o
);

        logic [exu_pkg::XLEN-1:0] imm_sext;

        // sign-extended I immediate for operand Y
        assign imm_sext = {{(exu_pkg::XLEN-12){instr_i.i_fmt.imm12[11]}},
                           instr_i.i_fmt.imm12};

        // --------------------------------------------------
        // operands, instruction and pc
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                x_o  <= rs1_i;
                y_o  <= ctl_imm_i ? imm_sext : rs2_i;
                ir_o <= instr_i;
                pc_o <= pc_i;
        end

        // --------------------------------------------------
        // class flags live for one cycle per strobe
        // --------------------------------------------------
        always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                        valid_o    <= 1'b0;
                        lui_o      <= 1'b0;
                        auipc_o    <= 1'b0;
                        jal_o      <= 1'b0;
                        jalr_o     <= 1'b0;
                        branch_o   <= 1'b0;
                        rd_write_o <= 1'b0;
                end else begin
                        valid_o    <= enable_i;
                        lui_o      <= enable_i & ctl_lui_i;
                        auipc_o    <= enable_i & ctl_auipc_i;
                        jal_o      <= enable_i & ctl_jal_i;
                        jalr_o     <= enable_i & ctl_jalr_i;
                        branch_o   <= enable_i & ctl_branch_i;
                        rd_write_o <= enable_i & ctl_rd_write_i;
                end
        end

        // decoder hands over at most one instruction class
        a_one_class: assert property (@(posedge clk) disable iff (!reset_n)
                enable_i |-> $onehot0({ctl_lui_i, ctl_auipc_i, ctl_jal_i,
                                       ctl_jalr_i, ctl_branch_i}))
                else $error("more than one class flag on strobe");

endmodule

// File: rtl/exu_pkg.sv
package exu_pkg;

        // data path width
        localparam int XLEN = 32;

        // --------------------------------------------------
        // major opcodes
        // --------------------------------------------------
        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;
        localparam logic [6:0] OPC_JAL    = 7'b1101111;
        localparam logic [6:0] OPC_JALR   = 7'b1100111;
        localparam logic [6:0] OPC_LUI    = 7'b0110111;
        localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

        // alu funct3
        localparam logic [2:0] F3_ADD_SUB = 3'b000;
        localparam logic [2:0] F3_SLL     = 3'b001;
        localparam logic [2:0] F3_SLT     = 3'b010;
        localparam logic [2:0] F3_SLTU    = 3'b011;
        localparam logic [2:0] F3_XOR     = 3'b100;
        localparam logic [2:0] F3_SRL_SRA = 3'b101;
        localparam logic [2:0] F3_OR      = 3'b110;
        localparam logic [2:0] F3_AND     = 3'b111;

        // branch funct3 (010 and 011 unused)
        localparam logic [2:0] F3_BEQ  = 3'b000;
        localparam logic [2:0] F3_BNE  = 3'b001;
        localparam logic [2:0] F3_BLT  = 3'b100;
        localparam logic [2:0] F3_BGE  = 3'b101;
        localparam logic [2:0] F3_BLTU = 3'b110;
        localparam logic [2:0] F3_BGEU = 3'b111;

        // --------------------------------------------------
        // instruction formats
        // --------------------------------------------------
        typedef struct packed {
                logic [11:0] imm12;
                logic [4:0]  rs1;
                logic [2:0]  funct3;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } i_fmt_t;

        // offset bits scattered around rs1/rs2
        typedef struct packed {
                logic        imm12;
                logic [5:0]  imm10_5;
                logic [4:0]  rs2;
                logic [4:0]  rs1;
                logic [2:0]  funct3;
                logic [3:0]  imm4_1;
                logic        imm11;
                logic [6:0]  opcode;
        } b_fmt_t;

        typedef struct packed {
                logic        imm20;
                logic [9:0]  imm10_1;
                logic        imm11;
                logic [7:0]  imm19_12;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } j_fmt_t;

        typedef struct packed {
                logic [19:0] imm20;
                logic [4:0]  rd;
                logic [6:0]  opcode;
        } u_fmt_t;

        // one word, four decodings
        typedef union packed {
                i_fmt_t i_fmt;
                b_fmt_t b_fmt;
                j_fmt_t j_fmt;
                u_fmt_t u_fmt;
        } instr_u;

endpackage
